/* src/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

    localparam int xlen       = 32;  // Data and address width
    localparam int reg_addr_w = 5;   // Register index width

    // Major opcodes, inst[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_fmt;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u_fmt;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lh, mem_lw, mem_lbu,
        mem_lhu, mem_sb, mem_sh, mem_sw
    } mem_op_t;

    typedef enum logic [1:0] {opr1_rs1, opr1_pc, opr1_zero} opr1_sel_t;

    typedef enum logic [1:0] {opr2_rs2, opr2_imm, opr2_four} opr2_sel_t;

    // rel is pc + imm, reg is rs1 + imm
    typedef enum logic [1:0] {pc_seq, pc_rel, pc_reg} pc_sel_t;

endpackage

`default_nettype wire

/* src/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  frontend_pkg::inst_t                 inst,
    input  logic                                is_zero,   // Operands equal
    input  logic                                is_lt,     // Signed less than
    input  logic                                is_ltu,    // Unsigned less than
    output logic [frontend_pkg::xlen-1:0]       imm,
    output frontend_pkg::opr1_sel_t             opr1_sel,
    output frontend_pkg::opr2_sel_t             opr2_sel,
    output frontend_pkg::pc_sel_t               pc_sel,
    output frontend_pkg::alu_op_t               alu_op,
    output frontend_pkg::mem_op_t               mem_op,
    output logic                                gpr_we,
    output logic [frontend_pkg::reg_addr_w-1:0] rs1,
    output logic [frontend_pkg::reg_addr_w-1:0] rs2,
    output logic [frontend_pkg::reg_addr_w-1:0] rd
);

    logic [frontend_pkg::xlen-1:0] i_imm;
    logic [frontend_pkg::xlen-1:0] s_imm;
    logic [frontend_pkg::xlen-1:0] b_imm;
    logic [frontend_pkg::xlen-1:0] u_imm;
    logic [frontend_pkg::xlen-1:0] j_imm;
    logic [2:0]                    funct3;
    logic                          alt;        // inst[30]
    logic                          brh_taken;
    frontend_pkg::alu_op_t         f3_op;      // ALU function for OP and OP-IMM

    assign funct3 = inst.r_fmt.funct3;
    assign alt    = inst.r_fmt.funct7[5];
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    assign rd     = inst.r_fmt.rd;

    assign i_imm = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign s_imm = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.funct7, inst.r_fmt.rd};
    assign b_imm = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.rd[0],
                    inst.r_fmt.funct7[5:0], inst.r_fmt.rd[4:1], 1'b0};
    assign u_imm = {inst.u_fmt.imm20, 12'b0};
    assign j_imm = {{12{inst.r_fmt.funct7[6]}}, inst.r_fmt.rs1, inst.r_fmt.funct3,
                    inst.r_fmt.rs2[0], inst.r_fmt.funct7[5:0], inst.r_fmt.rs2[4:1], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  brh_taken = is_zero;   // beq
            3'b001:  brh_taken = !is_zero;  // bne
            3'b100:  brh_taken = is_lt;     // blt
            3'b101:  brh_taken = !is_lt;    // bge
            3'b110:  brh_taken = is_ltu;    // bltu
            3'b111:  brh_taken = !is_ltu;   // bgeu
            default: brh_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  f3_op = (alt && inst.r_fmt.opcode == frontend_pkg::opc_op) ?
                             frontend_pkg::alu_sub : frontend_pkg::alu_add;
            3'b001:  f3_op = frontend_pkg::alu_sll;
            3'b010:  f3_op = frontend_pkg::alu_slt;
            3'b011:  f3_op = frontend_pkg::alu_sltu;
            3'b100:  f3_op = frontend_pkg::alu_xor;
            3'b101:  f3_op = alt ? frontend_pkg::alu_sra : frontend_pkg::alu_srl;
            3'b110:  f3_op = frontend_pkg::alu_or;
            default: f3_op = frontend_pkg::alu_and;
        endcase
    end

    always_comb begin
        imm      = '0;
        opr1_sel = frontend_pkg::opr1_rs1;
        opr2_sel = frontend_pkg::opr2_rs2;
        pc_sel   = frontend_pkg::pc_seq;
        alu_op   = frontend_pkg::alu_add;
        mem_op   = frontend_pkg::mem_none;
        gpr_we   = 1'b0;
        case (inst.r_fmt.opcode)
            frontend_pkg::opc_lui: begin
                imm      = u_imm;
                opr1_sel = frontend_pkg::opr1_zero;  // 0 + imm
                opr2_sel = frontend_pkg::opr2_imm;
                gpr_we   = 1'b1;
            end
            frontend_pkg::opc_auipc: begin
                imm      = u_imm;
                opr1_sel = frontend_pkg::opr1_pc;
                opr2_sel = frontend_pkg::opr2_imm;
                gpr_we   = 1'b1;
            end
            frontend_pkg::opc_jal, frontend_pkg::opc_jalr: begin
                imm      = (inst.r_fmt.opcode == frontend_pkg::opc_jal) ? j_imm : i_imm;
                pc_sel   = (inst.r_fmt.opcode == frontend_pkg::opc_jal) ?
                           frontend_pkg::pc_rel : frontend_pkg::pc_reg;
                opr1_sel = frontend_pkg::opr1_pc;    // Link address pc + 4
                opr2_sel = frontend_pkg::opr2_four;
                gpr_we   = 1'b1;
            end
            frontend_pkg::opc_branch: begin
                imm    = b_imm;
                alu_op = frontend_pkg::alu_sub;      // Flags come from rs1 - rs2
                pc_sel = brh_taken ? frontend_pkg::pc_rel : frontend_pkg::pc_seq;
            end
            frontend_pkg::opc_load: begin
                imm      = i_imm;
                opr2_sel = frontend_pkg::opr2_imm;
                gpr_we   = 1'b1;
                case (funct3)
                    3'b000:  mem_op = frontend_pkg::mem_lb;
                    3'b001:  mem_op = frontend_pkg::mem_lh;
                    3'b010:  mem_op = frontend_pkg::mem_lw;
                    3'b100:  mem_op = frontend_pkg::mem_lbu;
                    3'b101:  mem_op = frontend_pkg::mem_lhu;
                    default: mem_op = frontend_pkg::mem_none;
                endcase
            end
            frontend_pkg::opc_store: begin
                imm      = s_imm;
                opr2_sel = frontend_pkg::opr2_imm;
                case (funct3)
                    3'b000:  mem_op = frontend_pkg::mem_sb;
                    3'b001:  mem_op = frontend_pkg::mem_sh;
                    3'b010:  mem_op = frontend_pkg::mem_sw;
                    default: mem_op = frontend_pkg::mem_none;
                endcase
            end
            frontend_pkg::opc_op_imm: begin
                imm      = i_imm;
                opr2_sel = frontend_pkg::opr2_imm;
                alu_op   = f3_op;
                gpr_we   = 1'b1;
            end
            frontend_pkg::opc_op: begin
                alu_op = f3_op;
                gpr_we = 1'b1;
            end
            default: ;  // Unknown opcode acts as a nop
        endcase
    end

endmodule

`default_nettype wire

/* src/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter logic [frontend_pkg::xlen-1:0] reset_addr = '0
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  frontend_pkg::pc_sel_t         pc_sel,
    input  logic [frontend_pkg::xlen-1:0] imm,
    input  logic [frontend_pkg::xlen-1:0] rs1_data,
    output logic [frontend_pkg::xlen-1:0] pc
);

    localparam logic [frontend_pkg::xlen-1:0] four = 4;

    logic [frontend_pkg::xlen-1:0] pc_base;
    logic [frontend_pkg::xlen-1:0] pc_offs;
    logic [frontend_pkg::xlen-1:0] next_pc;

    assign pc_base = (pc_sel == frontend_pkg::pc_reg) ? rs1_data : pc;  // JALR base
    assign pc_offs = (pc_sel == frontend_pkg::pc_seq) ? four : imm;
    // Bit 0 of a JALR target is kept as is
    assign next_pc = pc_base + pc_offs;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_addr;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* src/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [frontend_pkg::reg_addr_w-1:0] rs1,
    input  logic [frontend_pkg::reg_addr_w-1:0] rs2,
    input  logic [frontend_pkg::reg_addr_w-1:0] rd,
    input  logic                                gpr_we,
    input  logic [frontend_pkg::xlen-1:0]       gpr_di,
    output logic [frontend_pkg::xlen-1:0]       rs1_data,
    output logic [frontend_pkg::xlen-1:0]       rs2_data
);

    localparam int depth = 2 ** frontend_pkg::reg_addr_w;

    // Single array shared by both read ports
    logic [frontend_pkg::xlen-1:0] regs [depth];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_we && rd != '0) begin  // x0 is never written
            regs[rd] <= gpr_di;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* src/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  frontend_pkg::opr1_sel_t       opr1_sel,
    input  frontend_pkg::opr2_sel_t       opr2_sel,
    input  logic [frontend_pkg::xlen-1:0] pc,
    input  logic [frontend_pkg::xlen-1:0] rs1_data,
    input  logic [frontend_pkg::xlen-1:0] rs2_data,
    input  logic [frontend_pkg::xlen-1:0] imm,
    output logic [frontend_pkg::xlen-1:0] alu_opr_1,
    output logic [frontend_pkg::xlen-1:0] alu_opr_2
);

    localparam logic [frontend_pkg::xlen-1:0] four = 4;

    always_comb begin
        case (opr1_sel)
            frontend_pkg::opr1_pc:   alu_opr_1 = pc;
            frontend_pkg::opr1_zero: alu_opr_1 = '0;   // LUI passes imm through
            default:                 alu_opr_1 = rs1_data;
        endcase
    end

    always_comb begin
        case (opr2_sel)
            frontend_pkg::opr2_imm:  alu_opr_2 = imm;
            frontend_pkg::opr2_four: alu_opr_2 = four;  // Link address
            default:                 alu_opr_2 = rs2_data;
        endcase
    end

endmodule

`default_nettype wire

/* src/frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend #(
    parameter logic [frontend_pkg::xlen-1:0] reset_addr = '0  // PC after reset
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  frontend_pkg::inst_t           inst,       // Word at current pc
    input  logic                          is_zero,
    input  logic                          is_lt,
    input  logic                          is_ltu,
    input  logic [frontend_pkg::xlen-1:0] gpr_di,     // Write-back data for rd
    output logic [frontend_pkg::xlen-1:0] pc,
    output logic [frontend_pkg::xlen-1:0] alu_opr_1,
    output logic [frontend_pkg::xlen-1:0] alu_opr_2,
    output logic [frontend_pkg::xlen-1:0] mem_di,     // Store data
    output frontend_pkg::alu_op_t         alu_op,
    output frontend_pkg::mem_op_t         mem_op
);

    logic [frontend_pkg::xlen-1:0]       imm;
    frontend_pkg::opr1_sel_t             opr1_sel;
    frontend_pkg::opr2_sel_t             opr2_sel;
    frontend_pkg::pc_sel_t               pc_sel;
    logic                                gpr_we;
    logic [frontend_pkg::reg_addr_w-1:0] rs1;
    logic [frontend_pkg::reg_addr_w-1:0] rs2;
    logic [frontend_pkg::reg_addr_w-1:0] rd;
    logic [frontend_pkg::xlen-1:0]       rs1_data;
    logic [frontend_pkg::xlen-1:0]       rs2_data;

    inst_decoder u_inst_decoder (
        .inst     (inst),
        .is_zero  (is_zero),
        .is_lt    (is_lt),
        .is_ltu   (is_ltu),
        .imm      (imm),
        .opr1_sel (opr1_sel),
        .opr2_sel (opr2_sel),
        .pc_sel   (pc_sel),
        .alu_op   (alu_op),
        .mem_op   (mem_op),
        .gpr_we   (gpr_we),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd)
    );

    pc_unit #(
        .reset_addr (reset_addr)
    ) u_pc_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .pc_sel   (pc_sel),
        .imm      (imm),
        .rs1_data (rs1_data),
        .pc       (pc)
    );

    gpr_file u_gpr_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .gpr_we   (gpr_we),
        .gpr_di   (gpr_di),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    operand_select u_operand_select (
        .opr1_sel  (opr1_sel),
        .opr2_sel  (opr2_sel),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .alu_opr_1 (alu_opr_1),
        .alu_opr_2 (alu_opr_2)
    );

    assign mem_di = rs2_data;  // Port b feeds the store path

endmodule

`default_nettype wire

/* tests/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

    localparam logic [31:0] reset_addr = 32'h0000_0100;
    localparam logic [31:0] nop        = 32'h0000_0013;  // addi x0, x0, 0
    localparam int n_seq  = 8;
    localparam int n_reg  = 12;
    localparam int n_imm  = 40;
    localparam int n_alu  = 32;
    localparam int n_flow = 24;
    // Reset, all words, one wait per test
    localparam int total_cycles = 4 + n_seq + 2 * n_reg + 2 + n_imm + n_alu + n_flow + 5;

    logic                  clk;
    logic                  arst_n;
    frontend_pkg::inst_t   inst;
    logic                  is_zero;
    logic                  is_lt;
    logic                  is_ltu;
    logic [31:0]           gpr_di;
    logic [31:0]           pc;
    logic [31:0]           alu_opr_1;
    logic [31:0]           alu_opr_2;
    logic [31:0]           mem_di;
    frontend_pkg::alu_op_t alu_op;
    frontend_pkg::mem_op_t mem_op;

    logic [31:0] model_regs [32];  // Reference register state
    logic [31:0] model_pc;
    logic        checking;
    integer      seed;
    int          n_checks;
    int          n_errors;
    int          base_checks;
    int          base_errors;

    frontend #(
        .reset_addr (reset_addr)
    ) u_frontend (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst      (inst),
        .is_zero   (is_zero),
        .is_lt     (is_lt),
        .is_ltu    (is_ltu),
        .gpr_di    (gpr_di),
        .pc        (pc),
        .alu_opr_1 (alu_opr_1),
        .alu_opr_2 (alu_opr_2),
        .mem_di    (mem_di),
        .alu_op    (alu_op),
        .mem_op    (mem_op)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] pack_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] pack_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm12, rs1, f3, rd, opc};
    endfunction

    // Expected outputs of one word against the model state
    function automatic void predict(
        input  logic [31:0] w,
        input  logic        z,
        input  logic        lt,
        input  logic        ltu,
        output logic [31:0] e_opr1,
        output logic [31:0] e_opr2,
        output logic [31:0] e_next_pc,
        output logic [3:0]  e_alu,
        output logic [3:0]  e_mem,
        output logic        e_we
    );
        logic [31:0] r1;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
        logic [31:0] u_imm;
        logic [31:0] j_imm;
        logic [3:0]  f3_op;
        logic        taken;
        r1    = model_regs[w[19:15]];
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'h000};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (w[14:12])
            3'd0:    f3_op = (w[30] && w[6:0] == frontend_pkg::opc_op) ?
                             frontend_pkg::alu_sub : frontend_pkg::alu_add;
            3'd1:    f3_op = frontend_pkg::alu_sll;
            3'd2:    f3_op = frontend_pkg::alu_slt;
            3'd3:    f3_op = frontend_pkg::alu_sltu;
            3'd4:    f3_op = frontend_pkg::alu_xor;
            3'd5:    f3_op = w[30] ? frontend_pkg::alu_sra : frontend_pkg::alu_srl;
            3'd6:    f3_op = frontend_pkg::alu_or;
            default: f3_op = frontend_pkg::alu_and;
        endcase
        case (w[14:12])
            3'd0:    taken = z;
            3'd1:    taken = !z;
            3'd4:    taken = lt;
            3'd5:    taken = !lt;
            3'd6:    taken = ltu;
            3'd7:    taken = !ltu;
            default: taken = 1'b0;  // Codes 2 and 3
        endcase
        e_opr1    = r1;
        e_opr2    = model_regs[w[24:20]];
        e_next_pc = model_pc + 32'd4;
        e_alu     = frontend_pkg::alu_add;
        e_mem     = frontend_pkg::mem_none;
        e_we      = 1'b0;
        case (w[6:0])
            frontend_pkg::opc_lui: begin
                e_opr1 = 32'h0;
                e_opr2 = u_imm;
                e_we   = 1'b1;
            end
            frontend_pkg::opc_auipc: begin
                e_opr1 = model_pc;
                e_opr2 = u_imm;
                e_we   = 1'b1;
            end
            frontend_pkg::opc_jal: begin
                e_opr1    = model_pc;
                e_opr2    = 32'd4;
                e_next_pc = model_pc + j_imm;
                e_we      = 1'b1;
            end
            frontend_pkg::opc_jalr: begin
                e_opr1    = model_pc;
                e_opr2    = 32'd4;
                e_next_pc = r1 + i_imm;  // Bit 0 stays
                e_we      = 1'b1;
            end
            frontend_pkg::opc_branch: begin
                e_alu = frontend_pkg::alu_sub;
                if (taken) begin
                    e_next_pc = model_pc + b_imm;
                end
            end
            frontend_pkg::opc_load: begin
                e_opr2 = i_imm;
                e_we   = 1'b1;
                case (w[14:12])
                    3'd0:    e_mem = frontend_pkg::mem_lb;
                    3'd1:    e_mem = frontend_pkg::mem_lh;
                    3'd2:    e_mem = frontend_pkg::mem_lw;
                    3'd4:    e_mem = frontend_pkg::mem_lbu;
                    3'd5:    e_mem = frontend_pkg::mem_lhu;
                    default: e_mem = frontend_pkg::mem_none;
                endcase
            end
            frontend_pkg::opc_store: begin
                e_opr2 = s_imm;
                case (w[14:12])
                    3'd0:    e_mem = frontend_pkg::mem_sb;
                    3'd1:    e_mem = frontend_pkg::mem_sh;
                    3'd2:    e_mem = frontend_pkg::mem_sw;
                    default: e_mem = frontend_pkg::mem_none;
                endcase
            end
            frontend_pkg::opc_op_imm: begin
                e_opr2 = i_imm;
                e_alu  = f3_op;
                e_we   = 1'b1;
            end
            frontend_pkg::opc_op: begin
                e_alu = f3_op;
                e_we  = 1'b1;
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s expected %h got %h", name, expected, actual);
        end
    endtask

    // One word per rising edge, flags random every cycle
    task automatic issue(input logic [31:0] w, input logic [31:0] di);
        logic [31:0] flags;
        flags = $random(seed);
        @(posedge clk);
        inst    <= w;
        gpr_di  <= di;
        is_zero <= flags[0];
        is_lt   <= flags[1];
        is_ltu  <= flags[2];
    endtask

    task automatic report_test(input string name);
        @(negedge clk);
        #1;  // Let the last compare settle
        $display("test %-8s %0d checks, %0d errors", name,
                 n_checks - base_checks, n_errors - base_errors);
        base_checks = n_checks;
        base_errors = n_errors;
    endtask

    always @(negedge clk) begin : compare_outputs
        logic [31:0] w;
        logic [31:0] e_opr1;
        logic [31:0] e_opr2;
        logic [31:0] e_next_pc;
        logic [3:0]  e_alu;
        logic [3:0]  e_mem;
        logic        e_we;
        if (checking) begin
            w = inst;
            predict(w, is_zero, is_lt, is_ltu, e_opr1, e_opr2, e_next_pc, e_alu, e_mem, e_we);
            check_value("pc", model_pc, pc);
            check_value("alu_opr_1", e_opr1, alu_opr_1);
            check_value("alu_opr_2", e_opr2, alu_opr_2);
            check_value("mem_di", model_regs[w[24:20]], mem_di);
            check_value("alu_op", {28'h0, e_alu}, {28'h0, alu_op});
            check_value("mem_op", {28'h0, e_mem}, {28'h0, mem_op});
            if (e_we && w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = gpr_di;  // Lands at the coming edge
            end
            model_pc = e_next_pc;
        end
    end

    task automatic reset_and_step();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("pc", reset_addr, pc);
        @(posedge clk);
        arst_n   <= 1'b1;
        checking = 1'b1;
        for (int k = 0; k < n_seq; k++) begin
            issue(nop, $random(seed));
        end
        report_test("reset");
    endtask

    task automatic reg_write_readback();
        logic [31:0] w;
        logic [4:0]  rd;
        for (int k = 0; k < n_reg; k++) begin
            w  = $random(seed);
            rd = w[11:7];
            issue(pack_i(w[31:20], 5'd0, 3'd0, rd, frontend_pkg::opc_op_imm), $random(seed));
            w = $random(seed);
            issue(pack_r(7'd0, w[24:20], rd, 3'd0, 5'd0, frontend_pkg::opc_op), $random(seed));
        end
        // x0 takes the write but must still read zero
        issue(pack_i(12'h7ff, 5'd0, 3'd0, 5'd0, frontend_pkg::opc_op_imm), 32'hdead_beef);
        issue(pack_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd1, frontend_pkg::opc_op), $random(seed));
        report_test("regs");
    endtask

    task automatic immediate_forms();
        logic [31:0] w;
        logic [6:0]  opcs [5];
        opcs = '{frontend_pkg::opc_lui, frontend_pkg::opc_auipc, frontend_pkg::opc_op_imm,
                 frontend_pkg::opc_load, frontend_pkg::opc_store};
        for (int k = 0; k < n_imm; k++) begin
            w      = $random(seed);
            w[6:0] = opcs[k % 5];
            issue(w, $random(seed));
        end
        report_test("imm");
    endtask

    task automatic alu_decode();
        logic [31:0] w;
        for (int k = 0; k < n_alu; k++) begin
            w        = $random(seed);
            w[6:0]   = (k < 16) ? frontend_pkg::opc_op : frontend_pkg::opc_op_imm;
            w[14:12] = k[2:0];
            w[30]    = k[3];
            issue(w, $random(seed));
        end
        report_test("alu");
    endtask

    task automatic control_flow();
        logic [31:0] w;
        for (int k = 0; k < 16; k++) begin
            w        = $random(seed);
            w[6:0]   = frontend_pkg::opc_branch;
            w[14:12] = k[2:0];  // All codes, 2 and 3 included
            issue(w, $random(seed));
        end
        for (int k = 0; k < n_flow - 16; k++) begin
            w      = $random(seed);
            w[6:0] = k[0] ? frontend_pkg::opc_jalr : frontend_pkg::opc_jal;
            issue(w, $random(seed));
        end
        report_test("flow");
    endtask

    initial begin
        seed        = 59798;
        clk         = 1'b0;
        arst_n      = 1'b0;
        inst        = nop;
        is_zero     = 1'b0;
        is_lt       = 1'b0;
        is_ltu      = 1'b0;
        gpr_di      = 32'h0;
        checking    = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        base_checks = 0;
        base_errors = 0;
        model_pc    = reset_addr;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        reset_and_step();
        reg_write_readback();
        immediate_forms();
        alu_decode();
        control_flow();
        checking = 1'b0;
        $display("total %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(total_cycles * 40 + 400);
        $display("Run timed out after %0d expected cycles", total_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/frontend_pkg.sv
src/inst_decoder.sv
src/pc_unit.sv
src/gpr_file.sv
src/operand_select.sv
src/frontend.sv
tests/frontend_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = frontend_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
